// ==== ctlb.f ====
+incdir+src
src/ctlb_pkg.sv
src/ctlb_ram.sv
src/ctlb_way.sv
src/ctlb_lru.sv
src/ctlb_init.sv
src/ctlb_csr.sv
src/ctlb.sv
verif/ctlb_tb.sv

// ==== src/ctlb.sv ====
`timescale 1ns/10ps
`include "ctlb_settings.svh"

module ctlb (
  input  logic                clk,
  input  logic                rst,
  input  logic                stall,
  input  logic                lookup_en,
  input  ctlb_pkg::vaddr_t    vaddr,
  input  logic                fill_en,
  input  ctlb_pkg::tlb_data_t fill_data,
  input  ctlb_pkg::apb_req_t  apb_req,
  output ctlb_pkg::apb_rsp_t  apb_rsp,
  output logic                hit,
  output ctlb_pkg::tlb_data_t hit_data,
  output logic                ready
);
  import ctlb_pkg::*;

  age_t      [`CTLB_WAYS-1:0] ages_rd;
  age_t      [`CTLB_WAYS-1:0] ages_wr;
  logic      [`CTLB_WAYS-1:0] way_hit;
  logic      [`CTLB_WAYS-1:0] fill_pending;
  tlb_data_t [`CTLB_WAYS-1:0] way_data;
  tlb_data_t                  hit_mux;
  asid_t                      cur_asid;
  logic                       sweep_busy;
  index_t                     sweep_index;

  for (genvar w = 0; w < `CTLB_WAYS; w++)
  begin : g_way
    ctlb_way #(
      .way_no (w)
    ) i_way (
      .clk          (clk),
      .rst          (rst),
      .stall        (stall),
      .lookup_en    (lookup_en),
      .vaddr        (vaddr),
      .cur_asid     (cur_asid),
      .fill_en      (fill_en),
      .fill_data    (fill_data),
      .sweep_busy   (sweep_busy),
      .sweep_index  (sweep_index),
      .age_out      (ages_wr[w]),
      .age_in       (ages_rd[w]),
      .way_hit      (way_hit[w]),
      .way_data     (way_data[w]),
      .fill_pending (fill_pending[w])
    );
  end

  ctlb_lru i_lru (
    .ages_in      (ages_rd),
    .hit_way      (way_hit),
    .fill_pending (|fill_pending), // all ways share the fill stage.
    .ages_out     (ages_wr)
  );

  ctlb_init i_init (
    .clk         (clk),
    .rst         (rst),
    .sweep_busy  (sweep_busy),
    .sweep_index (sweep_index)
  );

  ctlb_csr i_csr (
    .clk      (clk),
    .rst      (rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .cur_asid (cur_asid)
  );

  assign ready = ~sweep_busy;

  always_comb
  begin
    hit_mux = '0;
    for (int w = 0; w < `CTLB_WAYS; w++)
    begin
      if (way_hit[w])
      begin
        hit_mux = hit_mux | way_data[w];
      end
    end
  end

  assign hit      = ready & (|way_hit); // nothing hits during the sweep.
  assign hit_data = hit ? hit_mux : '0;

endmodule

// ==== src/ctlb_csr.sv ====
`timescale 1ns/10ps
`include "ctlb_settings.svh"

module ctlb_csr (
  input  logic               clk,
  input  logic               rst,
  input  ctlb_pkg::apb_req_t apb_req,
  output ctlb_pkg::apb_rsp_t apb_rsp,
  output ctlb_pkg::asid_t    cur_asid
);
  import ctlb_pkg::*;

  asid_t asid_q;
  logic  enable_q;
  logic  access;
  logic  sel_asid;
  logic  sel_ctrl;

  assign access   = apb_req.psel & apb_req.penable;
  assign sel_asid = (apb_req.paddr == `CTLB_REG_ASID);
  assign sel_ctrl = (apb_req.paddr == `CTLB_REG_CTRL);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      asid_q   <= '0;
      enable_q <= 1'b0;
    end
    else if (access && apb_req.pwrite)
    begin
      if (sel_asid)
      begin
        asid_q <= apb_req.pwdata[`CTLB_ASID_W-1:0];
      end
      if (sel_ctrl)
      begin
        enable_q <= apb_req.pwdata[0];
      end
    end
  end

  always_comb
  begin
    apb_rsp.pready  = 1'b1; // no wait states.
    apb_rsp.pslverr = access & ~(sel_asid | sel_ctrl);
    apb_rsp.prdata  = '0;
    if (access && !apb_req.pwrite)
    begin
      if (sel_asid)
      begin
        apb_rsp.prdata = 32'(asid_q);
      end
      else if (sel_ctrl)
      begin
        apb_rsp.prdata = {31'd0, enable_q};
      end
    end
  end

  // translation off behaves as address space zero.
  assign cur_asid = enable_q ? asid_q : '0;

  a_apb_setup: assert property (@(posedge clk) disable iff (rst)
    $rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel))
    else $error("ctlb_csr: penable without a setup phase");

endmodule

// ==== src/ctlb_init.sv ====
`timescale 1ns/10ps
`include "ctlb_settings.svh"

module ctlb_init (
  input  logic             clk,
  input  logic             rst,
  output logic             sweep_busy,
  output ctlb_pkg::index_t sweep_index
);
  import ctlb_pkg::*;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sweep_busy  <= 1'b1;
      sweep_index <= '0;
    end
    else if (sweep_busy)
    begin
      sweep_index <= sweep_index + 1'b1; // wraps to 0 at the end.
      if (sweep_index == index_t'(`CTLB_SETS-1))
      begin
        sweep_busy <= 1'b0;
      end
    end
  end

endmodule

// ==== src/ctlb_lru.sv ====
`timescale 1ns/10ps
`include "ctlb_settings.svh"

module ctlb_lru (
  input  ctlb_pkg::age_t [`CTLB_WAYS-1:0] ages_in,
  input  logic [`CTLB_WAYS-1:0]           hit_way,
  input  logic                            fill_pending,
  output ctlb_pkg::age_t [`CTLB_WAYS-1:0] ages_out
);
  import ctlb_pkg::*;

  logic [`CTLB_WAYS-1:0] touched;
  age_t                  touched_age;
  logic [`CTLB_WAYS-1:0] in_seen;
  logic [`CTLB_WAYS-1:0] out_seen;

  always_comb
  begin
    touched_age = '0;
    for (int i = 0; i < `CTLB_WAYS; i++)
    begin
      touched[i] = fill_pending ? (ages_in[i] == '0) : hit_way[i]; // victim on fill.
      if (touched[i])
      begin
        touched_age = touched_age | ages_in[i];
      end
    end
    for (int i = 0; i < `CTLB_WAYS; i++)
    begin
      if (!(|touched))
      begin
        ages_out[i] = ages_in[i];
      end
      else if (touched[i])
      begin
        ages_out[i] = 2'd3;
      end
      else if (ages_in[i] > touched_age)
      begin
        ages_out[i] = ages_in[i] - 2'd1;
      end
      else
      begin
        ages_out[i] = ages_in[i];
      end
    end
  end

  always_comb
  begin
    in_seen  = '0;
    out_seen = '0;
    for (int i = 0; i < `CTLB_WAYS; i++)
    begin
      in_seen  = in_seen | (4'b0001 << ages_in[i]);
      out_seen = out_seen | (4'b0001 << ages_out[i]);
    end
  end

  // a set holding each age once keeps doing so.
  always_comb
  begin
    if (in_seen == '1)
    begin
      a_age_perm: assert final (out_seen == '1)
        else $error("ctlb_lru: set ages no longer a permutation");
    end
  end

endmodule

// ==== src/ctlb_pkg.sv ====
`include "ctlb_settings.svh"

package ctlb_pkg;

  typedef logic [`CTLB_VADDR_W-1:0] vaddr_t;
  typedef logic [`CTLB_VADDR_W-`CTLB_PAGE_W-`CTLB_INDEX_W-1:0] tag_t;
  typedef logic [`CTLB_INDEX_W-1:0] index_t;
  typedef logic [`CTLB_ASID_W-1:0] asid_t;
  typedef logic [1:0] age_t; // 3 is most recent.

  // translation payload returned on a hit.
  typedef struct packed {
    logic [`CTLB_PPN_W-1:0] ppn;
    logic                   gbl; // matches in any address space.
    logic                   user;
    logic                   exec;
  } tlb_data_t;

  typedef struct packed {
    logic      valid;
    tag_t      tag;
    asid_t     asid;
    age_t      age;
    tlb_data_t data;
  } tlb_entry_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

// ==== src/ctlb_ram.sv ====
`timescale 1ns/10ps
`include "ctlb_settings.svh"

module ctlb_ram (
  input  logic                 clk,
  input  ctlb_pkg::index_t     rd_index,
  output ctlb_pkg::tlb_entry_t rd_entry,
  input  ctlb_pkg::index_t     wr_index,
  input  ctlb_pkg::tlb_entry_t wr_entry,
  input  logic                 wr_en
);
  import ctlb_pkg::*;

  tlb_entry_t mem [0:`CTLB_SETS-1];

  assign rd_entry = mem[rd_index]; // async read.

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_index] <= wr_entry;
    end
  end

endmodule

// ==== src/ctlb_settings.svh ====
`ifndef CTLB_SETTINGS_SVH
`define CTLB_SETTINGS_SVH

// tlb geometry.
`define CTLB_WAYS     4
`define CTLB_SETS     64
`define CTLB_INDEX_W  6

// address and field widths.
`define CTLB_VADDR_W  48
`define CTLB_PAGE_W   12
`define CTLB_ASID_W   16
`define CTLB_PPN_W    28

// apb register offsets.
`define CTLB_REG_ASID 8'h00
`define CTLB_REG_CTRL 8'h04

`endif

// ==== src/ctlb_way.sv ====
`timescale 1ns/10ps
`include "ctlb_settings.svh"

module ctlb_way #(
  parameter int way_no = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                stall,
  input  logic                lookup_en,
  input  ctlb_pkg::vaddr_t    vaddr,
  input  ctlb_pkg::asid_t     cur_asid,
  input  logic                fill_en,
  input  ctlb_pkg::tlb_data_t fill_data,
  input  logic                sweep_busy,
  input  ctlb_pkg::index_t    sweep_index,
  input  ctlb_pkg::age_t      age_out,
  output ctlb_pkg::age_t      age_in,
  output logic                way_hit,
  output ctlb_pkg::tlb_data_t way_data,
  output logic                fill_pending
);
  import ctlb_pkg::*;

  index_t     lk_index;
  tag_t       lk_tag;
  index_t     fill_index;
  tag_t       fill_tag;
  asid_t      fill_asid;
  tlb_data_t  fill_data_q;
  index_t     rd_index;
  index_t     wr_index;
  tlb_entry_t rd_entry;
  tlb_entry_t wr_entry;
  logic       wr_en;
  logic       asid_ok;

  assign lk_index = vaddr[`CTLB_PAGE_W +: `CTLB_INDEX_W];
  assign lk_tag   = vaddr[`CTLB_VADDR_W-1 -: $bits(tag_t)];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      fill_pending <= 1'b0;
    end
    else if (!stall)
    begin
      fill_pending <= fill_en & ~sweep_busy; // no fills during sweep.
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall && fill_en)
    begin
      fill_index  <= lk_index;
      fill_tag    <= lk_tag;
      fill_asid   <= cur_asid;
      fill_data_q <= fill_data;
    end
  end

  // pending fill steals the read port for its victim set.
  assign rd_index = fill_pending ? fill_index : lk_index;

  assign asid_ok  = (rd_entry.asid == cur_asid) | rd_entry.data.gbl;
  assign way_hit  = rd_entry.valid & ~fill_pending & (rd_entry.tag == lk_tag) & asid_ok;
  assign way_data = rd_entry.data;
  assign age_in   = rd_entry.age;

  assign wr_index = sweep_busy ? sweep_index : rd_index;
  assign wr_en    = sweep_busy | (~stall & (fill_pending | lookup_en));

  always_comb
  begin
    wr_entry = rd_entry;
    wr_entry.age = age_out; // age update, same entry.
    if (sweep_busy)
    begin
      wr_entry = '0;
      wr_entry.age = age_t'(way_no);
    end
    else if (fill_pending && rd_entry.age == '0)
    begin
      wr_entry.valid = 1'b1;
      wr_entry.tag   = fill_tag;
      wr_entry.asid  = fill_asid;
      wr_entry.age   = age_out;
      wr_entry.data  = fill_data_q;
    end
  end

  ctlb_ram i_ram (
    .clk      (clk),
    .rd_index (rd_index),
    .rd_entry (rd_entry),
    .wr_index (wr_index),
    .wr_entry (wr_entry),
    .wr_en    (wr_en)
  );

  // fill source must leave a gap after each request.
  a_fill_gap: assert property (@(posedge clk) disable iff (rst)
    fill_pending && !stall |-> !fill_en)
    else $error("ctlb_way%0d: fill issued while one is pending", way_no);

endmodule

// ==== verif/ctlb_tb.sv ====
`timescale 1ns/10ps
`include "ctlb_settings.svh"

module ctlb_tb;
  import ctlb_pkg::*;

  localparam int test_cycles = 100 + 20 + 80 + 60 + 40; // sweep, fill, replace, asid, apb.

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  logic      stall = 1'b0;
  logic      lookup_en = 1'b0;
  vaddr_t    vaddr = '0;
  logic      fill_en = 1'b0;
  tlb_data_t fill_data = '0;
  apb_req_t  apb_req = '0;
  apb_rsp_t  apb_rsp;
  logic      hit;
  tlb_data_t hit_data;
  logic      ready;

  logic [15:0] lfsr_q = 16'd50368;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_passed = 0;

  // reference model of the entry array and registers.
  logic      m_valid [0:`CTLB_SETS-1][0:`CTLB_WAYS-1];
  tag_t      m_tag   [0:`CTLB_SETS-1][0:`CTLB_WAYS-1];
  asid_t     m_asid  [0:`CTLB_SETS-1][0:`CTLB_WAYS-1];
  age_t      m_age   [0:`CTLB_SETS-1][0:`CTLB_WAYS-1];
  tlb_data_t m_data  [0:`CTLB_SETS-1][0:`CTLB_WAYS-1];
  asid_t     m_asid_reg = '0;
  logic      m_en = 1'b0;

  ctlb i_ctlb (.*);

  always #50 clk = ~clk;

  initial
  begin
    repeat (2000 + test_cycles) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]; // x^16+x^14+x^13+x^11.
      lfsr_q = {lfsr_q[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic vaddr_t make_vaddr(input tag_t t, input index_t s);
    logic [31:0] offs;
    offs = rand_bits(`CTLB_PAGE_W); // offset plays no part in the match.
    return {t, s, offs[`CTLB_PAGE_W-1:0]};
  endfunction

  function automatic tlb_data_t make_data();
    logic [31:0] r;
    r = rand_bits($bits(tlb_data_t));
    return r[$bits(tlb_data_t)-1:0];
  endfunction

  function automatic int model_find(input vaddr_t va);
    index_t s;
    tag_t   t;
    asid_t  cur;
    s   = va[`CTLB_PAGE_W +: `CTLB_INDEX_W];
    t   = va[`CTLB_VADDR_W-1:`CTLB_PAGE_W+`CTLB_INDEX_W];
    cur = m_en ? m_asid_reg : '0;
    for (int w = 0; w < `CTLB_WAYS; w++)
    begin
      if (m_valid[s][w] && m_tag[s][w] == t && (m_asid[s][w] == cur || m_data[s][w].gbl))
        return w;
    end
    return -1;
  endfunction

  function automatic void model_touch(input index_t s, input int w);
    age_t t;
    t = m_age[s][w];
    for (int i = 0; i < `CTLB_WAYS; i++)
    begin
      if (i == w)
        m_age[s][i] = 2'd3;
      else if (m_age[s][i] > t)
        m_age[s][i] = m_age[s][i] - 2'd1;
    end
  endfunction

  function automatic void model_fill(input vaddr_t va, input tlb_data_t d);
    index_t s;
    s = va[`CTLB_PAGE_W +: `CTLB_INDEX_W];
    for (int w = 0; w < `CTLB_WAYS; w++)
    begin
      if (m_age[s][w] == 2'd0) // oldest way is the victim.
      begin
        m_valid[s][w] = 1'b1;
        m_tag[s][w]   = va[`CTLB_VADDR_W-1:`CTLB_PAGE_W+`CTLB_INDEX_W];
        m_asid[s][w]  = m_en ? m_asid_reg : '0;
        m_data[s][w]  = d;
        model_touch(s, w);
        return;
      end
    end
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0)
      tests_passed++;
    $display("%s: %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic lookup_check(input vaddr_t va);
    int        w;
    index_t    s;
    tlb_data_t exp_data;
    s = va[`CTLB_PAGE_W +: `CTLB_INDEX_W];
    w = model_find(va);
    exp_data = (w < 0) ? '0 : m_data[s][w];
    @(posedge clk);
    lookup_en <= 1'b1;
    vaddr     <= va;
    @(negedge clk);
    if (hit !== (w >= 0))
      report_error($sformatf("mismatch hit: got %h expected %h", hit, w >= 0));
    if (hit_data !== exp_data)
      report_error($sformatf("mismatch hit_data: got %h expected %h", hit_data, exp_data));
    @(posedge clk);
    lookup_en <= 1'b0;
    if (w >= 0 && !stall)
      model_touch(s, w); // ages move on this edge.
  endtask

  task automatic fill_issue(input vaddr_t va, input tlb_data_t d);
    @(posedge clk);
    fill_en   <= 1'b1;
    vaddr     <= va;
    fill_data <= d;
    @(posedge clk);
    fill_en <= 1'b0;
    @(negedge clk);
    if (hit !== 1'b0)
      report_error("lookup hit while a fill was still pending");
    @(posedge clk);
    model_fill(va, d);
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    logic exp_err;
    exp_err = (addr != `CTLB_REG_ASID) && (addr != `CTLB_REG_CTRL);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    if (apb_rsp.pready !== 1'b1)
      report_error("pready was low in the access phase");
    if (apb_rsp.pslverr !== exp_err)
      report_error($sformatf("mismatch pslverr: got %h expected %h", apb_rsp.pslverr, exp_err));
    @(posedge clk);
    apb_req <= '0;
    if (wr && addr == `CTLB_REG_ASID)
      m_asid_reg = wdata[`CTLB_ASID_W-1:0];
    if (wr && addr == `CTLB_REG_CTRL)
      m_en = wdata[0];
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    apb_access(1'b1, addr, data, rdata);
  endtask

  task automatic apb_read_check(input logic [7:0] addr);
    logic [31:0] exp_data;
    logic [31:0] rdata;
    exp_data = '0;
    if (addr == `CTLB_REG_ASID)
      exp_data = 32'(m_asid_reg);
    else if (addr == `CTLB_REG_CTRL)
      exp_data = {31'd0, m_en};
    apb_access(1'b0, addr, '0, rdata);
    if (rdata !== exp_data)
      report_error($sformatf("mismatch prdata: got %h expected %h", rdata, exp_data));
  endtask

  task automatic test_sweep();
    int cycles;
    for (int s = 0; s < `CTLB_SETS; s++)
    begin
      for (int w = 0; w < `CTLB_WAYS; w++)
      begin
        m_valid[s][w] = 1'b0;
        m_age[s][w]   = age_t'(w);
      end
    end
    repeat (10) @(posedge clk);
    rst       <= 1'b0;
    lookup_en <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!ready && cycles < 2 * `CTLB_SETS)
    begin
      if (hit !== 1'b0)
        report_error("lookup hit while the sweep was running");
      cycles++;
      @(posedge clk);
      vaddr <= make_vaddr(tag_t'(rand_bits(30)), index_t'(rand_bits(`CTLB_INDEX_W)));
      @(negedge clk);
    end
    if (cycles != `CTLB_SETS)
      report_error($sformatf("mismatch ready_low_cycles: got %h expected %h", cycles, `CTLB_SETS));
    @(posedge clk);
    lookup_en <= 1'b0;
    for (int i = 0; i < 4; i++)
      lookup_check(make_vaddr(tag_t'(rand_bits(30)), index_t'(rand_bits(`CTLB_INDEX_W))));
    finish_test("sweep");
  endtask

  task automatic test_fill();
    tag_t      t;
    index_t    s;
    tlb_data_t d;
    t = tag_t'(rand_bits(30));
    s = index_t'(rand_bits(`CTLB_INDEX_W));
    d = make_data();
    fill_issue(make_vaddr(t, s), d);
    lookup_check(make_vaddr(t, s));
    lookup_check(make_vaddr(t, s + 6'd1)); // same tag, other set.
    finish_test("fill");
  endtask

  task automatic test_replace();
    tag_t      t [0:5];
    tlb_data_t d [0:5];
    index_t    s;
    vaddr_t    va_held;
    int        w_held;
    tlb_data_t exp_held;
    s = index_t'(rand_bits(`CTLB_INDEX_W));
    for (int i = 0; i < 6; i++)
    begin
      t[i] = tag_t'({rand_bits(27), 3'(i)}); // low bits keep tags distinct.
      d[i] = make_data();
    end
    for (int i = 0; i < 4; i++)
      fill_issue(make_vaddr(t[i], s), d[i]);
    lookup_check(make_vaddr(t[0], s));
    lookup_check(make_vaddr(t[2], s));
    fill_issue(make_vaddr(t[4], s), d[4]);
    for (int i = 0; i < 5; i++)
      lookup_check(make_vaddr(t[i], s));
    va_held  = make_vaddr(t[4], s);
    w_held   = model_find(va_held);
    exp_held = (w_held < 0) ? '0 : m_data[s][w_held];
    @(posedge clk);
    stall     <= 1'b1;
    fill_en   <= 1'b1;
    vaddr     <= va_held; // lookups go on while stalled.
    fill_data <= d[5];
    repeat (3)
    begin
      @(negedge clk);
      if (hit !== (w_held >= 0))
        report_error($sformatf("mismatch hit: got %h expected %h", hit, w_held >= 0));
      if (hit_data !== exp_held)
        report_error($sformatf("mismatch hit_data: got %h expected %h", hit_data, exp_held));
    end
    @(posedge clk);
    stall <= 1'b0;
    vaddr <= make_vaddr(t[5], s); // fill address, taken once stall is low.
    @(posedge clk);
    fill_en <= 1'b0; // registered on this edge.
    @(posedge clk);
    model_fill(make_vaddr(t[5], s), d[5]);
    for (int i = 0; i < 6; i++)
      lookup_check(make_vaddr(t[i], s));
    finish_test("replace");
  endtask

  task automatic test_asid();
    asid_t     a;
    tag_t      tn;
    tag_t      tg;
    index_t    s;
    tlb_data_t dn;
    tlb_data_t dg;
    a  = asid_t'(rand_bits(`CTLB_ASID_W)) | 16'h0001; // never zero.
    tn = tag_t'(rand_bits(30));
    tg = tn ^ 30'h1;
    s  = index_t'(rand_bits(`CTLB_INDEX_W));
    dn = make_data();
    dn.gbl = 1'b0;
    dg = make_data();
    dg.gbl = 1'b1;
    apb_write(`CTLB_REG_ASID, 32'(a));
    apb_write(`CTLB_REG_CTRL, 32'h1);
    fill_issue(make_vaddr(tn, s), dn);
    fill_issue(make_vaddr(tg, s), dg);
    lookup_check(make_vaddr(tn, s));
    lookup_check(make_vaddr(tg, s));
    apb_write(`CTLB_REG_ASID, 32'(a ^ 16'h00ff));
    lookup_check(make_vaddr(tn, s));
    lookup_check(make_vaddr(tg, s));
    apb_write(`CTLB_REG_ASID, 32'(a));
    lookup_check(make_vaddr(tn, s));
    apb_write(`CTLB_REG_CTRL, 32'h0);
    lookup_check(make_vaddr(tn, s));
    lookup_check(make_vaddr(tg, s));
    finish_test("asid");
  endtask

  task automatic test_apb();
    apb_write(`CTLB_REG_ASID, 32'hdead_5a3c);
    apb_read_check(`CTLB_REG_ASID);
    apb_write(`CTLB_REG_CTRL, 32'hffff_ffff);
    apb_read_check(`CTLB_REG_CTRL);
    apb_write(8'h08, 32'h0000_0000);
    apb_write(8'h0c, 32'h0000_0000);
    apb_read_check(`CTLB_REG_ASID);
    apb_read_check(`CTLB_REG_CTRL);
    apb_read_check(8'h08);
    finish_test("apb");
  endtask

  initial
  begin
    test_sweep();
    test_fill();
    test_replace();
    test_asid();
    test_apb();
    $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule
